//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // ==================================================
  // widths and fetch block geometry
  // ==================================================
  localparam int VADDR_W = 32;
  typedef logic [VADDR_W-1:0] vaddr_t;

  localparam int FETCH_BLOCK_BYTES = 8;  // one cache access
  localparam int FETCH_DATA_W = 64;
  typedef logic [FETCH_DATA_W-1:0] fetch_data_t;

  localparam vaddr_t PC_INIT_VAL = 32'h8000_0000;  // boot vector

  localparam int MEDELEG_W = 16;  // only the low exception codes are delegable here

  // ==================================================
  // commit causes
  // ==================================================
  // trap causes keep their riscv mcause code so they index medeleg directly
  typedef enum logic [4:0] {
    INST_ADDR_MISALIGN = 5'd0,
    INST_ACC_FAULT     = 5'd1,
    ILLEGAL_INST       = 5'd2,
    ECALL_U            = 5'd8,
    ECALL_S            = 5'd9,
    ECALL_M            = 5'd11,
    INST_PAGE_FAULT    = 5'd12,
    // flush kinds, outside the trap code range
    SILENT_FLUSH       = 5'd16,  // resume after the instruction
    ANOTHER_FLUSH      = 5'd17,  // replay the instruction
    MRET               = 5'd18,
    SRET               = 5'd19
  } except_t;

  // machine interrupt codes, scaled by 4 into the vectored mtvec table
  localparam logic [3:0] INT_M_SOFT  = 4'd3;
  localparam logic [3:0] INT_M_TIMER = 4'd7;
  localparam logic [3:0] INT_M_EXT   = 4'd11;

  // ==================================================
  // fetch FSM
  // ==================================================
  typedef enum logic [2:0] {
    INIT            = 3'd0,
    FETCH_REQ       = 3'd1,  // one request per cycle
    WAIT_IC_FILL    = 3'd2,  // cache refilling after a miss
    WAIT_IBUF_FREE  = 3'd3,  // buffer pushed back
    WAIT_FLUSH_FREE = 3'd4   // redirect seen while cache busy
  } fetch_state_t;

endpackage

`default_nettype wire

//--- hdl/redirect_target.sv
`default_nettype none

module redirect_target (
  // commit side
  input  wire logic                            i_commit_flush,
  input  wire fetch_pkg::except_t              i_commit_cause,
  input  wire fetch_pkg::vaddr_t               i_commit_epc,
  // interrupts, qualified by i_commit_flush
  input  wire logic                            i_int_m_ext,
  input  wire logic                            i_int_m_timer,
  input  wire logic                            i_int_m_soft,
  // csr state
  input  wire fetch_pkg::vaddr_t               i_csr_mtvec,
  input  wire fetch_pkg::vaddr_t               i_csr_stvec,
  input  wire fetch_pkg::vaddr_t               i_csr_mepc,
  input  wire fetch_pkg::vaddr_t               i_csr_sepc,
  input  wire logic [fetch_pkg::MEDELEG_W-1:0] i_csr_medeleg,
  // branch resolution
  input  wire logic                            i_br_mispredict,
  input  wire fetch_pkg::vaddr_t               i_br_target,

  output logic                                 o_redirect_valid,
  output fetch_pkg::vaddr_t                    o_redirect_vaddr
);

  fetch_pkg::vaddr_t w_int_base;
  fetch_pkg::vaddr_t w_trap_vaddr;
  logic              w_deleg;

  // vectored mode base, mode bit dropped
  assign w_int_base = {i_csr_mtvec[fetch_pkg::VADDR_W-1:1], 1'b0};

  // each trap looks up its own medeleg bit
  assign w_deleg      = i_csr_medeleg[i_commit_cause[3:0]];
  assign w_trap_vaddr = w_deleg ? i_csr_stvec : i_csr_mtvec;

  assign o_redirect_valid = i_commit_flush | i_br_mispredict;

  always_comb begin
    o_redirect_vaddr = '0;
    if (i_commit_flush) begin
      // interrupts win over the commit cause
      if (i_int_m_ext) begin
        o_redirect_vaddr = w_int_base + fetch_pkg::vaddr_t'({fetch_pkg::INT_M_EXT, 2'b00});
      end else if (i_int_m_timer) begin
        o_redirect_vaddr = w_int_base + fetch_pkg::vaddr_t'({fetch_pkg::INT_M_TIMER, 2'b00});
      end else if (i_int_m_soft) begin
        o_redirect_vaddr = w_int_base + fetch_pkg::vaddr_t'({fetch_pkg::INT_M_SOFT, 2'b00});
      end else begin
        case (i_commit_cause)
          fetch_pkg::SILENT_FLUSH  : o_redirect_vaddr = i_commit_epc + 4;
          fetch_pkg::ANOTHER_FLUSH : o_redirect_vaddr = i_commit_epc;
          fetch_pkg::MRET          : o_redirect_vaddr = i_csr_mepc;
          fetch_pkg::SRET          : o_redirect_vaddr = i_csr_sepc;
          fetch_pkg::INST_ADDR_MISALIGN,
          fetch_pkg::INST_ACC_FAULT,
          fetch_pkg::ILLEGAL_INST,
          fetch_pkg::ECALL_U,
          fetch_pkg::ECALL_S,
          fetch_pkg::ECALL_M,
          fetch_pkg::INST_PAGE_FAULT : begin
            o_redirect_vaddr = w_trap_vaddr;
          end
          default : o_redirect_vaddr = '0;  // unknown cause
        endcase
      end
    end else if (i_br_mispredict) begin
      o_redirect_vaddr = i_br_target;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl (
  input  wire logic              i_clk,
  input  wire logic              i_reset_n,

  input  wire logic              i_redirect_valid,
  input  wire fetch_pkg::vaddr_t i_redirect_vaddr,

  input  wire logic              i_ic_ready,
  input  wire logic              i_ibuf_ready,

  // retry information from s2
  input  wire logic              i_s2_miss,
  input  wire logic              i_s2_stall,
  input  wire fetch_pkg::vaddr_t i_s2_vaddr,

  output logic                   o_ic_req_valid,
  output fetch_pkg::vaddr_t      o_ic_req_vaddr,
  output logic                   o_req_fire,
  output fetch_pkg::vaddr_t      o_req_vaddr
);

  fetch_pkg::fetch_state_t r_state;
  fetch_pkg::fetch_state_t w_state_next;
  fetch_pkg::vaddr_t       r_s0_vaddr;  // next address to request
  fetch_pkg::vaddr_t       w_s0_vaddr_next;
  fetch_pkg::vaddr_t       w_req_vaddr;
  logic                    w_req_valid;
  logic                    w_wakeup;

  // start of the block after the one holding vaddr
  function automatic fetch_pkg::vaddr_t next_block(input fetch_pkg::vaddr_t vaddr);
    fetch_pkg::vaddr_t mask;
    mask = ~fetch_pkg::vaddr_t'(fetch_pkg::FETCH_BLOCK_BYTES - 1);
    return (vaddr & mask) + fetch_pkg::vaddr_t'(fetch_pkg::FETCH_BLOCK_BYTES);
  endfunction

  // ==================================================
  // wait state release
  // ==================================================
  always_comb begin
    case (r_state)
      fetch_pkg::WAIT_IC_FILL    : w_wakeup = i_ic_ready;  // refill done
      fetch_pkg::WAIT_FLUSH_FREE : w_wakeup = i_ic_ready;
      fetch_pkg::WAIT_IBUF_FREE  : w_wakeup = i_ic_ready & i_ibuf_ready;
      default                    : w_wakeup = 1'b0;
    endcase
  end

  // ==================================================
  // next state and next pc
  // ==================================================
  always_comb begin
    w_state_next    = r_state;
    w_s0_vaddr_next = r_s0_vaddr;
    if (r_state != fetch_pkg::INIT && i_redirect_valid) begin
      if (i_ic_ready) begin
        // target goes out this cycle
        w_state_next    = fetch_pkg::FETCH_REQ;
        w_s0_vaddr_next = next_block(i_redirect_vaddr);
      end else begin
        w_state_next    = fetch_pkg::WAIT_FLUSH_FREE;
        w_s0_vaddr_next = i_redirect_vaddr;
      end
    end else begin
      case (r_state)
        fetch_pkg::INIT : w_state_next = fetch_pkg::FETCH_REQ;
        fetch_pkg::FETCH_REQ : begin
          if (i_s2_miss) begin
            w_state_next    = fetch_pkg::WAIT_IC_FILL;
            w_s0_vaddr_next = i_s2_vaddr;
          end else if (i_s2_stall) begin
            w_state_next    = fetch_pkg::WAIT_IBUF_FREE;
            w_s0_vaddr_next = i_s2_vaddr;  // refetch the rejected block
          end else if (i_ic_ready) begin
            w_s0_vaddr_next = next_block(r_s0_vaddr);
          end
        end
        default : begin
          // held address goes out on release
          if (w_wakeup) begin
            w_state_next    = fetch_pkg::FETCH_REQ;
            w_s0_vaddr_next = next_block(r_s0_vaddr);
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= fetch_pkg::INIT;
      r_s0_vaddr <= fetch_pkg::PC_INIT_VAL;
    end else begin
      r_state    <= w_state_next;
      r_s0_vaddr <= w_s0_vaddr_next;
    end
  end

  // request only while staying in or returning to FETCH_REQ
  assign w_req_valid = (r_state != fetch_pkg::INIT) & (w_state_next == fetch_pkg::FETCH_REQ);
  assign w_req_vaddr = i_redirect_valid ? i_redirect_vaddr : r_s0_vaddr;

  assign o_ic_req_valid = w_req_valid;
  assign o_ic_req_vaddr = w_req_vaddr;
  assign o_req_fire     = w_req_valid & i_ic_ready;
  assign o_req_vaddr    = w_req_vaddr;

endmodule

`default_nettype wire

//--- hdl/fetch_pipe.sv
`default_nettype none

module fetch_pipe (
  input  wire logic                   i_clk,
  input  wire logic                   i_reset_n,

  input  wire logic                   i_req_fire,  // accepted by the cache
  input  wire fetch_pkg::vaddr_t      i_req_vaddr,
  input  wire logic                   i_redirect_valid,

  input  wire logic                   i_ic_resp_valid,
  input  wire fetch_pkg::fetch_data_t i_ic_resp_data,
  input  wire logic                   i_ic_miss,
  input  wire logic                   i_ibuf_ready,

  output logic                        o_s2_miss,
  output logic                        o_s2_stall,
  output fetch_pkg::vaddr_t           o_s2_vaddr,

  output logic                        o_fetch_valid,
  output fetch_pkg::vaddr_t           o_fetch_vaddr,
  output fetch_pkg::fetch_data_t      o_fetch_data
);

  logic              r_s1_valid;
  logic              r_s1_clear;
  fetch_pkg::vaddr_t r_s1_vaddr;
  logic              r_s2_valid;
  logic              r_s2_clear;
  fetch_pkg::vaddr_t r_s2_vaddr;
  logic              w_s2_live;
  logic              w_s2_retry;

  assign w_s2_live  = r_s2_valid & ~r_s2_clear;
  assign o_s2_miss  = w_s2_live & i_ic_miss;
  assign o_s2_stall = w_s2_live & i_ic_resp_valid & ~i_ibuf_ready;
  assign w_s2_retry = o_s2_miss | o_s2_stall;

  // ==================================================
  // stage registers
  // ==================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s1_clear <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_clear <= 1'b0;
    end else begin
      r_s1_valid <= i_req_fire;
      // a redirect request is younger than the flush
      r_s1_clear <= ~i_redirect_valid & w_s2_retry;
      r_s2_valid <= r_s1_valid;
      r_s2_clear <= r_s1_clear | i_redirect_valid | w_s2_retry;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr <= i_req_vaddr;
    r_s2_vaddr <= r_s1_vaddr;
  end

  assign o_s2_vaddr = r_s2_vaddr;

  // flushed blocks never reach the buffer
  assign o_fetch_valid = w_s2_live & i_ic_resp_valid & i_ibuf_ready & ~i_redirect_valid;
  assign o_fetch_vaddr = r_s2_vaddr;
  assign o_fetch_data  = i_ic_resp_data;

endmodule

`default_nettype wire

//--- hdl/fetch_frontend.sv
`default_nettype none

module fetch_frontend (
  input  wire logic                            i_clk,
  input  wire logic                            i_reset_n,

  input  wire logic                            i_commit_flush,
  input  wire fetch_pkg::except_t              i_commit_cause,
  input  wire fetch_pkg::vaddr_t               i_commit_epc,
  input  wire logic                            i_int_m_ext,
  input  wire logic                            i_int_m_timer,
  input  wire logic                            i_int_m_soft,

  input  wire fetch_pkg::vaddr_t               i_csr_mtvec,
  input  wire fetch_pkg::vaddr_t               i_csr_stvec,
  input  wire fetch_pkg::vaddr_t               i_csr_mepc,
  input  wire fetch_pkg::vaddr_t               i_csr_sepc,
  input  wire logic [fetch_pkg::MEDELEG_W-1:0] i_csr_medeleg,

  input  wire logic                            i_br_mispredict,
  input  wire fetch_pkg::vaddr_t               i_br_target,

  // icache
  output logic                                 o_ic_req_valid,
  output fetch_pkg::vaddr_t                    o_ic_req_vaddr,
  input  wire logic                            i_ic_ready,
  input  wire logic                            i_ic_resp_valid,
  input  wire fetch_pkg::fetch_data_t          i_ic_resp_data,
  input  wire logic                            i_ic_miss,

  // instruction buffer
  input  wire logic                            i_ibuf_ready,
  output logic                                 o_fetch_valid,
  output fetch_pkg::vaddr_t                    o_fetch_vaddr,
  output fetch_pkg::fetch_data_t               o_fetch_data
);

  logic              w_redirect_valid;
  fetch_pkg::vaddr_t w_redirect_vaddr;
  logic              w_req_fire;
  fetch_pkg::vaddr_t w_req_vaddr;
  logic              w_s2_miss;
  logic              w_s2_stall;
  fetch_pkg::vaddr_t w_s2_vaddr;

  redirect_target u_redirect_target (
    .i_commit_flush   (i_commit_flush),
    .i_commit_cause   (i_commit_cause),
    .i_commit_epc     (i_commit_epc),
    .i_int_m_ext      (i_int_m_ext),
    .i_int_m_timer    (i_int_m_timer),
    .i_int_m_soft     (i_int_m_soft),
    .i_csr_mtvec      (i_csr_mtvec),
    .i_csr_stvec      (i_csr_stvec),
    .i_csr_mepc       (i_csr_mepc),
    .i_csr_sepc       (i_csr_sepc),
    .i_csr_medeleg    (i_csr_medeleg),
    .i_br_mispredict  (i_br_mispredict),
    .i_br_target      (i_br_target),
    .o_redirect_valid (w_redirect_valid),
    .o_redirect_vaddr (w_redirect_vaddr)
  );

  fetch_ctrl u_fetch_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_redirect_valid (w_redirect_valid),
    .i_redirect_vaddr (w_redirect_vaddr),
    .i_ic_ready       (i_ic_ready),
    .i_ibuf_ready     (i_ibuf_ready),
    .i_s2_miss        (w_s2_miss),
    .i_s2_stall       (w_s2_stall),
    .i_s2_vaddr       (w_s2_vaddr),
    .o_ic_req_valid   (o_ic_req_valid),
    .o_ic_req_vaddr   (o_ic_req_vaddr),
    .o_req_fire       (w_req_fire),
    .o_req_vaddr      (w_req_vaddr)
  );

  fetch_pipe u_fetch_pipe (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_req_fire       (w_req_fire),
    .i_req_vaddr      (w_req_vaddr),
    .i_redirect_valid (w_redirect_valid),
    .i_ic_resp_valid  (i_ic_resp_valid),
    .i_ic_resp_data   (i_ic_resp_data),
    .i_ic_miss        (i_ic_miss),
    .i_ibuf_ready     (i_ibuf_ready),
    .o_s2_miss        (w_s2_miss),
    .o_s2_stall       (w_s2_stall),
    .o_s2_vaddr       (w_s2_vaddr),
    .o_fetch_valid    (o_fetch_valid),
    .o_fetch_vaddr    (o_fetch_vaddr),
    .o_fetch_data     (o_fetch_data)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;  // 10 ns period
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/fetch_frontend_properties.sv
`default_nettype none

module fetch_frontend_properties (
  input wire logic i_clk,
  input wire logic i_reset_n,
  input wire logic i_ic_req_valid,
  input wire logic i_fetch_valid,
  input wire logic i_ibuf_ready,
  input wire logic i_s2_miss,
  input wire logic i_s2_stall
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // assertion failures so far

  // no cache traffic while held in reset
  req_low_in_reset : assert property (@(posedge i_clk) !i_reset_n |-> !i_ic_req_valid)
    else begin
      fail_count++;
      $error("cache request raised during reset");
    end

  deliver_only_when_ready : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_fetch_valid |-> i_ibuf_ready)
    else begin
      fail_count++;
      $error("block delivered to a busy instruction buffer");
    end

  miss_xor_stall : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_s2_miss && i_s2_stall))
    else begin
      fail_count++;
      $error("s2 miss and s2 stall raised together");
    end

endmodule

bind fetch_frontend fetch_frontend_properties u_props (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_ic_req_valid (o_ic_req_valid),
  .i_fetch_valid  (o_fetch_valid),
  .i_ibuf_ready   (i_ibuf_ready),
  .i_s2_miss      (w_s2_miss),
  .i_s2_stall     (w_s2_stall)
);

`default_nettype wire

//--- dv/tb_fetch_frontend.sv
`default_nettype none

module tb_fetch_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  // ==================================================
  // constants and stimulus state
  // ==================================================
  // reset, about 30 redirect or stall sequences of under 20 cycles, and wide margin
  localparam int MAX_CYCLES = 2000;
  localparam int MISS_HOLD  = 4;  // cycles of low ready, miss cycle included
  localparam fetch_pkg::vaddr_t MTVEC = 32'h8000_1001;  // mode bit set
  localparam fetch_pkg::vaddr_t STVEC = 32'h8000_2000;
  localparam fetch_pkg::vaddr_t MEPC  = 32'h8000_3004;
  localparam fetch_pkg::vaddr_t SEPC  = 32'h8000_4008;
  localparam fetch_pkg::vaddr_t EPC   = 32'h8000_5010;

  logic clk;
  logic reset_n;
  logic commit_flush;
  fetch_pkg::except_t commit_cause;
  fetch_pkg::vaddr_t commit_epc;
  logic int_m_ext;
  logic int_m_timer;
  logic int_m_soft;
  fetch_pkg::vaddr_t csr_mtvec;
  fetch_pkg::vaddr_t csr_stvec;
  fetch_pkg::vaddr_t csr_mepc;
  fetch_pkg::vaddr_t csr_sepc;
  logic [fetch_pkg::MEDELEG_W-1:0] csr_medeleg;
  logic br_mispredict;
  fetch_pkg::vaddr_t br_target;
  logic ibuf_ready;
  logic ic_ready = 1'b1;
  logic ic_resp_valid = 1'b0;
  fetch_pkg::fetch_data_t ic_resp_data = '0;
  logic ic_miss = 1'b0;
  logic ic_req_valid;
  fetch_pkg::vaddr_t ic_req_vaddr;
  logic fetch_valid;
  fetch_pkg::vaddr_t fetch_vaddr;
  fetch_pkg::fetch_data_t fetch_data;

  // cache model pipeline, two cycles deep
  logic p1_valid = 1'b0;
  logic p2_valid = 1'b0;
  fetch_pkg::vaddr_t p1_vaddr;
  fetch_pkg::vaddr_t p2_vaddr;
  int ready_hold = 0;
  logic miss_armed = 1'b0;
  logic miss_seen = 1'b0;
  fetch_pkg::vaddr_t miss_vaddr = '0;

  fetch_pkg::vaddr_t seen_vaddr[$];  // blocks taken by the buffer
  fetch_pkg::fetch_data_t seen_data[$];
  fetch_pkg::vaddr_t next_vaddr;
  int cycle_count = 0;

  fetch_pkg::except_t traps[7] = '{fetch_pkg::INST_ADDR_MISALIGN, fetch_pkg::INST_ACC_FAULT,
    fetch_pkg::ILLEGAL_INST, fetch_pkg::ECALL_U, fetch_pkg::ECALL_S, fetch_pkg::ECALL_M,
    fetch_pkg::INST_PAGE_FAULT};

  tb_clock_gen u_clock_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  fetch_frontend uut (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_commit_flush  (commit_flush),
    .i_commit_cause  (commit_cause),
    .i_commit_epc    (commit_epc),
    .i_int_m_ext     (int_m_ext),
    .i_int_m_timer   (int_m_timer),
    .i_int_m_soft    (int_m_soft),
    .i_csr_mtvec     (csr_mtvec),
    .i_csr_stvec     (csr_stvec),
    .i_csr_mepc      (csr_mepc),
    .i_csr_sepc      (csr_sepc),
    .i_csr_medeleg   (csr_medeleg),
    .i_br_mispredict (br_mispredict),
    .i_br_target     (br_target),
    .o_ic_req_valid  (ic_req_valid),
    .o_ic_req_vaddr  (ic_req_vaddr),
    .i_ic_ready      (ic_ready),
    .i_ic_resp_valid (ic_resp_valid),
    .i_ic_resp_data  (ic_resp_data),
    .i_ic_miss       (ic_miss),
    .i_ibuf_ready    (ibuf_ready),
    .o_fetch_valid   (fetch_valid),
    .o_fetch_vaddr   (fetch_vaddr),
    .o_fetch_data    (fetch_data)
  );

  // ==================================================
  // helpers
  // ==================================================
  function automatic fetch_pkg::fetch_data_t block_data(input fetch_pkg::vaddr_t vaddr);
    return {vaddr ^ 32'h5a5a_a5a5, ~vaddr};
  endfunction

  // aligned start of the following block
  function automatic fetch_pkg::vaddr_t step_block(input fetch_pkg::vaddr_t vaddr);
    fetch_pkg::vaddr_t bytes;
    bytes = fetch_pkg::vaddr_t'(fetch_pkg::FETCH_BLOCK_BYTES);
    return (vaddr & ~(bytes - 1)) + bytes;
  endfunction

  function automatic fetch_pkg::vaddr_t irq_vector(input int code);
    return (MTVEC & ~32'h1) + fetch_pkg::vaddr_t'(code * 4);
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_vaddr(input string name, input fetch_pkg::vaddr_t exp,
                             input fetch_pkg::vaddr_t act);
    if (exp !== act) begin
      stop_run($sformatf("FAILED %s: vaddr expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_data(input string name, input fetch_pkg::fetch_data_t exp,
                            input fetch_pkg::fetch_data_t act);
    if (exp !== act) begin
      stop_run($sformatf("FAILED %s: data expected %h, actual %h", name, exp, act));
    end
  endtask

  // ==================================================
  // cache model and delivery monitor
  // ==================================================
  always @(posedge clk) begin
    p1_valid <= ic_req_valid & ic_ready;
    p1_vaddr <= ic_req_vaddr;
    p2_valid <= p1_valid;
    p2_vaddr <= p1_vaddr;
    if (reset_n && fetch_valid) begin
      seen_vaddr.push_back(fetch_vaddr);
      seen_data.push_back(fetch_data);
    end
  end

  always @(negedge clk) begin
    ic_miss       = 1'b0;
    ic_resp_valid = 1'b0;
    ic_resp_data  = '0;
    if (ready_hold != 0) ready_hold = ready_hold - 1;
    if (p2_valid) begin
      if (miss_armed && !miss_seen && p2_vaddr == miss_vaddr) begin
        miss_seen  = 1'b1;  // one miss only
        ic_miss    = 1'b1;
        ready_hold = MISS_HOLD;
      end else begin
        ic_resp_valid = 1'b1;
        ic_resp_data  = block_data(p2_vaddr);
      end
    end
    ic_ready = (ready_hold == 0);
  end

  // bound assertions and cycle limit
  always @(posedge clk) begin
    cycle_count++;
    if (uut.u_props.fail_count != 0) begin
      stop_run("a bound assertion on the fetch front end failed");
    end else if (cycle_count >= MAX_CYCLES) begin
      stop_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  // ==================================================
  // test tasks
  // ==================================================
  task automatic check_stream(input string name, input int count);
    for (int i = 0; i < count; i++) begin
      while (seen_vaddr.size() == 0) @(negedge clk);
      check_vaddr(name, next_vaddr, seen_vaddr.pop_front());
      check_data(name, block_data(next_vaddr), seen_data.pop_front());
      next_vaddr = step_block(next_vaddr);
    end
  endtask

  // redirect inputs are already driven for this cycle
  task automatic follow_redirect(input string name, input fetch_pkg::vaddr_t exp_vaddr);
    seen_vaddr.delete();
    seen_data.delete();
    @(negedge clk);
    commit_flush  = 1'b0;
    {int_m_ext, int_m_timer, int_m_soft} = 3'b000;
    br_mispredict = 1'b0;
    next_vaddr    = exp_vaddr;
    check_stream(name, 3);
  endtask

  task automatic commit_check(input string name, input fetch_pkg::except_t cause,
                              input logic [2:0] irq,
                              input logic [fetch_pkg::MEDELEG_W-1:0] medeleg,
                              input logic with_br, input fetch_pkg::vaddr_t exp_vaddr);
    @(negedge clk);
    commit_flush  = 1'b1;
    commit_cause  = cause;
    {int_m_ext, int_m_timer, int_m_soft} = irq;  // ext, timer, soft
    csr_medeleg   = medeleg;
    br_mispredict = with_br;
    br_target     = $urandom & 32'hffff_fffe;
    follow_redirect(name, exp_vaddr);
  endtask

  task automatic reset_stream_order();
    next_vaddr = fetch_pkg::PC_INIT_VAL;
    check_stream("reset_stream", 8);
  endtask

  task automatic icache_miss_retry();
    miss_vaddr = next_vaddr + 64;  // well past anything already requested
    miss_armed = 1'b1;
    check_stream("icache_miss", 14);
    if (!miss_seen) stop_run("the cache model never saw a request for the miss address");
  endtask

  task automatic ibuf_backpressure();
    int hold;
    int held;
    hold = 3 + ($urandom % 8);
    @(negedge clk);
    ibuf_ready = 1'b0;
    held = seen_vaddr.size();
    repeat (hold) @(negedge clk);
    if (seen_vaddr.size() != held) stop_run("a block was delivered while the buffer was full");
    ibuf_ready = 1'b1;
    check_stream("ibuf_backpressure", 8);
  endtask

  task automatic mispredict_redirect();
    fetch_pkg::vaddr_t target;
    target = $urandom & 32'hffff_fffe;
    @(negedge clk);
    br_mispredict = 1'b1;
    br_target     = target;
    follow_redirect("mispredict", target);
    check_stream("mispredict", 4);
  endtask

  task automatic commit_redirects();
    logic [fetch_pkg::MEDELEG_W-1:0] mask;
    commit_check("silent_flush", fetch_pkg::SILENT_FLUSH, 3'b000, '0, 1'b0, EPC + 4);
    commit_check("another_flush", fetch_pkg::ANOTHER_FLUSH, 3'b000, '0, 1'b0, EPC);
    commit_check("mret", fetch_pkg::MRET, 3'b000, '0, 1'b0, MEPC);
    commit_check("sret", fetch_pkg::SRET, 3'b000, '0, 1'b0, SEPC);
    foreach (traps[i]) begin
      mask = '0;
      mask[traps[i]] = 1'b1;
      commit_check({traps[i].name(), " delegated"}, traps[i], 3'b000, mask, 1'b0, STVEC);
      commit_check({traps[i].name(), " to m"}, traps[i], 3'b000, ~mask, 1'b0, MTVEC);
    end
    // delegated ecall underneath shows the interrupt taking over
    commit_check("int ext", fetch_pkg::ECALL_M, 3'b100, '1, 1'b0,
                 irq_vector(fetch_pkg::INT_M_EXT));
    commit_check("int timer", fetch_pkg::ECALL_M, 3'b010, '1, 1'b0,
                 irq_vector(fetch_pkg::INT_M_TIMER));
    commit_check("int soft", fetch_pkg::ECALL_M, 3'b001, '1, 1'b0,
                 irq_vector(fetch_pkg::INT_M_SOFT));
    commit_check("int all", fetch_pkg::ECALL_M, 3'b111, '1, 1'b0, irq_vector(fetch_pkg::INT_M_EXT));
    commit_check("int timer soft", fetch_pkg::ECALL_M, 3'b011, '1, 1'b0,
                 irq_vector(fetch_pkg::INT_M_TIMER));
    commit_check("int ext soft", fetch_pkg::ECALL_M, 3'b101, '1, 1'b0,
                 irq_vector(fetch_pkg::INT_M_EXT));
    commit_check("commit over mispredict", fetch_pkg::MRET, 3'b000, '0, 1'b1, MEPC);
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    void'($urandom(54855));
    commit_flush  = 1'b0;
    commit_cause  = fetch_pkg::SILENT_FLUSH;
    commit_epc    = EPC;
    int_m_ext     = 1'b0;
    int_m_timer   = 1'b0;
    int_m_soft    = 1'b0;
    csr_mtvec     = MTVEC;
    csr_stvec     = STVEC;
    csr_mepc      = MEPC;
    csr_sepc      = SEPC;
    csr_medeleg   = '0;
    br_mispredict = 1'b0;
    br_target     = '0;
    ibuf_ready    = 1'b1;
    next_vaddr    = fetch_pkg::PC_INIT_VAL;

    reset_stream_order();
    icache_miss_retry();
    ibuf_backpressure();
    mispredict_redirect();
    commit_redirects();

    repeat (2) @(negedge clk);
    if (uut.u_props.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hdl/fetch_pkg.sv
hdl/redirect_target.sv
hdl/fetch_ctrl.sv
hdl/fetch_pipe.sv
hdl/fetch_frontend.sv
dv/tb_clock_gen.sv
dv/fetch_frontend_properties.sv
dv/tb_fetch_frontend.sv
